/* rtl/adder_macros.svh */
// Operand width and client count for the shared adder
`ifndef ADDER_MACROS_SVH
`define ADDER_MACROS_SVH

// Han-Carlson tree is wired for this width only
`define ADD_WIDTH 14

// Ports on the shared adder arbiter
`define N_CLIENTS 2

`endif

/* rtl/adder_pkg.sv */
// Adder request and response structs, client index type and Ling prefix cell functions
`include "adder_macros.svh"

package adder_pkg;

	typedef struct packed {
		logic                  valid;
		logic [`ADD_WIDTH-1:0] a;
		logic [`ADD_WIDTH-1:0] b;
		logic                  cin;
	} add_req_t;

	typedef struct packed {
		logic                  valid;
		logic [`ADD_WIDTH-1:0] sum;
		logic                  cout;
	} add_rsp_t;

	// Index of a granted arbiter port
	typedef logic [$clog2(`N_CLIENTS)-1:0] client_id_t;

	// Black cell, group H of the upper pair extended by the lower one
	function automatic logic black_g(input logic [1:0] gin, input logic [1:0] pin);
		return gin[1] | (pin[1] & gin[0]);
	endfunction

	// Black cell, group I (also the I half of a reduced black cell)
	function automatic logic black_p(input logic [1:0] pin);
		return pin[1] & pin[0];
	endfunction

	// Grey cell, H only, group I of the upper span as a single bit
	function automatic logic grey_g(input logic [1:0] gin, input logic pin);
		return gin[1] | (pin & gin[0]);
	endfunction

	// First-stage Ling pseudo-carry needs no propagate term
	function automatic logic reduced_h(input logic [1:0] gin);
		return gin[1] | gin[0];
	endfunction

endpackage

/* rtl/ling_adder.sv */
// Ling-style 14-bit Han-Carlson prefix adder, purely combinational
`timescale 1ns/1ps
`include "adder_macros.svh"

module ling_adder
	import adder_pkg::*;
(
	input  logic [`ADD_WIDTH-1:0] a,
	input  logic [`ADD_WIDTH-1:0] b,
	input  logic                  cin,
	output logic [`ADD_WIDTH-1:0] sum,
	output logic                  cout
);

	// Position 0 of g carries cin, operand bit i sits at position i+1
	logic [`ADD_WIDTH:1] p;
	logic [`ADD_WIDTH:0] g;

	logic h_1_0, h_3_2, h_5_4, h_7_6, h_9_8, h_11_10, h_13_12;
	logic i_3_2, i_5_4, i_7_6, i_9_8, i_11_10, i_13_12;
	logic h_3_0, h_5_2, h_7_4, h_9_6, h_11_8, h_13_10;
	logic i_5_2, i_7_4, i_9_6, i_11_8, i_13_10;
	logic h_5_0, h_7_0, h_9_2, h_11_4, h_13_6;
	logic i_9_2, i_11_4, i_13_6;
	logic h_9_0, h_11_0, h_13_0;
	logic h_2_0, h_4_0, h_6_0, h_8_0, h_10_0, h_12_0;

	logic [`ADD_WIDTH-1:1] hp;
	logic [`ADD_WIDTH:1]   c;
	logic                  h_top;

	assign p = a | b;
	assign g = {a & b, cin};

	// Reduced first stage over pairs
	assign h_1_0   = reduced_h(g[1:0]);
	assign h_3_2   = reduced_h(g[3:2]);
	assign h_5_4   = reduced_h(g[5:4]);
	assign h_7_6   = reduced_h(g[7:6]);
	assign h_9_8   = reduced_h(g[9:8]);
	assign h_11_10 = reduced_h(g[11:10]);
	assign h_13_12 = reduced_h(g[13:12]);
	assign i_3_2   = black_p(p[2:1]);
	assign i_5_4   = black_p(p[4:3]);
	assign i_7_6   = black_p(p[6:5]);
	assign i_9_8   = black_p(p[8:7]);
	assign i_11_10 = black_p(p[10:9]);
	assign i_13_12 = black_p(p[12:11]);

	// Span of 4
	assign h_3_0   = grey_g({h_3_2, h_1_0}, i_3_2);
	assign h_5_2   = black_g({h_5_4, h_3_2}, {i_5_4, i_3_2});
	assign i_5_2   = black_p({i_5_4, i_3_2});
	assign h_7_4   = black_g({h_7_6, h_5_4}, {i_7_6, i_5_4});
	assign i_7_4   = black_p({i_7_6, i_5_4});
	assign h_9_6   = black_g({h_9_8, h_7_6}, {i_9_8, i_7_6});
	assign i_9_6   = black_p({i_9_8, i_7_6});
	assign h_11_8  = black_g({h_11_10, h_9_8}, {i_11_10, i_9_8});
	assign i_11_8  = black_p({i_11_10, i_9_8});
	assign h_13_10 = black_g({h_13_12, h_11_10}, {i_13_12, i_11_10});
	assign i_13_10 = black_p({i_13_12, i_11_10});

	// Span of 8
	assign h_5_0  = grey_g({h_5_2, h_1_0}, i_5_2);
	assign h_7_0  = grey_g({h_7_4, h_3_0}, i_7_4);
	assign h_9_2  = black_g({h_9_6, h_5_2}, {i_9_6, i_5_2});
	assign i_9_2  = black_p({i_9_6, i_5_2});
	assign h_11_4 = black_g({h_11_8, h_7_4}, {i_11_8, i_7_4});
	assign i_11_4 = black_p({i_11_8, i_7_4});
	assign h_13_6 = black_g({h_13_10, h_9_6}, {i_13_10, i_9_6});
	assign i_13_6 = black_p({i_13_10, i_9_6});

	// Odd positions complete here
	assign h_9_0  = grey_g({h_9_2, h_1_0}, i_9_2);
	assign h_11_0 = grey_g({h_11_4, h_3_0}, i_11_4);
	assign h_13_0 = grey_g({h_13_6, h_5_0}, i_13_6);

	// Even positions from their odd neighbour below
	assign h_2_0  = grey_g({g[2], h_1_0}, p[1]);
	assign h_4_0  = grey_g({g[4], h_3_0}, p[3]);
	assign h_6_0  = grey_g({g[6], h_5_0}, p[5]);
	assign h_8_0  = grey_g({g[8], h_7_0}, p[7]);
	assign h_10_0 = grey_g({g[10], h_9_0}, p[9]);
	assign h_12_0 = grey_g({g[12], h_11_0}, p[11]);

	assign hp = {h_13_0, h_12_0, h_11_0, h_10_0, h_9_0, h_8_0, h_7_0,
		h_6_0, h_5_0, h_4_0, h_3_0, h_2_0, h_1_0};

	// Real carry into position k+1 is p[k] and H at k
	assign c     = {p[`ADD_WIDTH-1:1] & hp, g[0]};
	assign h_top = g[`ADD_WIDTH] | c[`ADD_WIDTH];

	assign sum  = (p[`ADD_WIDTH:1] ^ {h_top, hp}) | (g[`ADD_WIDTH:1] & c);
	assign cout = p[`ADD_WIDTH] & h_top;

endmodule

/* rtl/adder_arbiter.sv */
// Round-robin arbiter in front of the shared Ling adder with a registered response
`timescale 1ns/1ps
`include "adder_macros.svh"

module adder_arbiter
	import adder_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  add_req_t              req [`N_CLIENTS],
	output logic [`N_CLIENTS-1:0] gnt,
	output add_rsp_t              rsp [`N_CLIENTS]
);

	client_id_t            last_gnt;
	client_id_t            sel;
	logic                  found;
	logic [`N_CLIENTS-1:0] req_valid;
	logic [`ADD_WIDTH-1:0] add_sum;
	logic                  add_cout;
	logic                  rsp_vld;
	client_id_t            rsp_dst;
	logic [`ADD_WIDTH-1:0] rsp_sum;
	logic                  rsp_cout;

	always_comb begin
		for (int i = 0; i < `N_CLIENTS; i++)
			req_valid[i] = req[i].valid;
	end

	// Search starts one past the last granted client
	always_comb begin
		int idx;
		sel   = last_gnt;
		found = 1'b0;
		gnt   = '0;
		for (int k = 1; k <= `N_CLIENTS; k++) begin
			idx = (int'(last_gnt) + k) % `N_CLIENTS;
			if (!found && req[idx].valid) begin
				found = 1'b1;
				sel   = client_id_t'(idx);
			end
		end
		if (found)
			gnt[sel] = 1'b1;
	end

	ling_adder i_adder (
		.a    (req[sel].a),
		.b    (req[sel].b),
		.cin  (req[sel].cin),
		.sum  (add_sum),
		.cout (add_cout)
	);

	// First contention goes to client 0
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_vld  <= 1'b0;
			rsp_dst  <= '0;
			last_gnt <= client_id_t'(`N_CLIENTS - 1);
		end else begin
			rsp_vld <= found;
			if (found) begin
				rsp_dst  <= sel;
				last_gnt <= sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		rsp_sum  <= add_sum;
		rsp_cout <= add_cout;
	end

	always_comb begin
		for (int i = 0; i < `N_CLIENTS; i++) begin
			rsp[i].valid = rsp_vld && (rsp_dst == client_id_t'(i));
			rsp[i].sum   = rsp_sum;
			rsp[i].cout  = rsp_cout;
		end
	end

	// One grant to a requester and never idle while one waits
	a_gnt_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(gnt) && ((gnt & ~req_valid) == '0) && ((gnt != '0) == (req_valid != '0)));

	// With every client waiting the last one granted is passed over
	a_gnt_rr: assert property (@(posedge clk) disable iff (reset)
		(&req_valid) |-> !gnt[last_gnt]);

	for (genvar gi = 0; gi < `N_CLIENTS; gi++) begin : g_rsp_chk
		// Response only ever follows a grant to the same port
		a_rsp_after_gnt: assert property (@(posedge clk) disable iff (reset)
			rsp[gi].valid |-> $past(gnt[gi]));
	end

endmodule

/* rtl/accum_client.sv */
// Running-sum accumulator client of the shared adder, modulo 2^14
`timescale 1ns/1ps
`include "adder_macros.svh"

module accum_client
	import adder_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sample_valid,
	input  logic [`ADD_WIDTH-1:0] sample,
	input  logic                  clear,
	output logic [`ADD_WIDTH-1:0] acc,
	output logic                  busy,
	output add_req_t              req,
	input  logic                  gnt,
	input  add_rsp_t              rsp
);

	logic                  req_vld;
	logic [`ADD_WIDTH-1:0] sample_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc     <= '0;
			busy    <= 1'b0;
			req_vld <= 1'b0;
		end else begin
			if (sample_valid && !busy) begin
				busy    <= 1'b1;
				req_vld <= 1'b1;
			end else if (clear && !busy) begin
				acc <= '0;
			end
			// Request drops once the arbiter takes it
			if (req_vld && gnt)
				req_vld <= 1'b0;
			// Carry out is dropped, sum wraps
			if (rsp.valid) begin
				acc  <= rsp.sum;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid && !busy)
			sample_q <= sample;
	end

	// acc stays put while the request is out
	always_comb begin
		req.valid = req_vld;
		req.a     = acc;
		req.b     = sample_q;
		req.cin   = 1'b0;
	end

	a_no_sample_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !sample_valid);

endmodule

/* rtl/csum_client.sv */
// Ones'-complement checksum client with an end-around carry fold pass
`timescale 1ns/1ps
`include "adder_macros.svh"

module csum_client
	import adder_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  word_valid,
	input  logic [`ADD_WIDTH-1:0] word,
	input  logic                  clear,
	output logic [`ADD_WIDTH-1:0] csum,
	output logic                  busy,
	output add_req_t              req,
	input  logic                  gnt,
	input  add_rsp_t              rsp
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ADD,
		S_FOLD
	} state_t;

	state_t                state;
	logic                  req_vld;
	logic [`ADD_WIDTH-1:0] word_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			req_vld <= 1'b0;
			csum    <= '0;
		end else begin
			if (req_vld && gnt)
				req_vld <= 1'b0;
			case (state)
				S_IDLE: begin
					if (word_valid) begin
						state   <= S_ADD;
						req_vld <= 1'b1;
					end else if (clear) begin
						csum <= '0;
					end
				end
				S_ADD: begin
					if (rsp.valid) begin
						csum <= rsp.sum;
						// End-around carry needs one more pass
						if (rsp.cout) begin
							state   <= S_FOLD;
							req_vld <= 1'b1;
						end else begin
							state <= S_IDLE;
						end
					end
				end
				S_FOLD: begin
					// Sum plus one cannot carry again
					if (rsp.valid) begin
						csum  <= rsp.sum;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && word_valid)
			word_q <= word;
	end

	assign busy = (state != S_IDLE);

	always_comb begin
		req.valid = req_vld;
		req.a     = csum;
		req.b     = (state == S_FOLD) ? '0 : word_q;
		req.cin   = (state == S_FOLD);
	end

	a_no_word_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !word_valid);

	// Fold pass result never carries out
	a_fold_no_carry: assert property (@(posedge clk) disable iff (reset)
		(state == S_FOLD && rsp.valid) |-> !rsp.cout);

endmodule

/* rtl/add_share_top.sv */
// Accumulator and checksum clients sharing one adder through the arbiter
`timescale 1ns/1ps
`include "adder_macros.svh"

module add_share_top
	import adder_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sample_valid,
	input  logic [`ADD_WIDTH-1:0] sample,
	input  logic                  acc_clear,
	output logic [`ADD_WIDTH-1:0] acc,
	output logic                  acc_busy,
	input  logic                  word_valid,
	input  logic [`ADD_WIDTH-1:0] word,
	input  logic                  csum_clear,
	output logic [`ADD_WIDTH-1:0] csum,
	output logic                  csum_busy
);

	// Port 0 is the accumulator, port 1 the checksum
	add_req_t              req [`N_CLIENTS];
	logic [`N_CLIENTS-1:0] gnt;
	add_rsp_t              rsp [`N_CLIENTS];

	accum_client i_accum (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.clear        (acc_clear),
		.acc          (acc),
		.busy         (acc_busy),
		.req          (req[0]),
		.gnt          (gnt[0]),
		.rsp          (rsp[0])
	);

	csum_client i_csum (
		.clk        (clk),
		.reset      (reset),
		.word_valid (word_valid),
		.word       (word),
		.clear      (csum_clear),
		.csum       (csum),
		.busy       (csum_busy),
		.req        (req[1]),
		.gnt        (gnt[1]),
		.rsp        (rsp[1])
	);

	adder_arbiter i_arbiter (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.gnt   (gnt),
		.rsp   (rsp)
	);

endmodule

/* dv/tb_clock.sv */
// Free-running testbench clock with a 100 ns period
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

/* dv/tb_add_share.sv */
// Testbench for the shared adder subsystem, directed cases from a file then random operations
`timescale 1ns/1ps
`include "adder_macros.svh"

module tb_add_share
	import adder_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RANDOM_OPS     = 60;

	logic                  clk;
	logic                  reset;
	logic                  sample_valid;
	logic [`ADD_WIDTH-1:0] sample;
	logic                  acc_clear;
	logic [`ADD_WIDTH-1:0] acc;
	logic                  acc_busy;
	logic                  word_valid;
	logic [`ADD_WIDTH-1:0] word;
	logic                  csum_clear;
	logic [`ADD_WIDTH-1:0] csum;
	logic                  csum_busy;

	int                    seed;
	int                    test_no;
	int                    pass_count;
	int                    fail_count;
	int                    error_count;
	bit                    timed_out;
	bit                    file_error;
	logic [`ADD_WIDTH-1:0] acc_model;
	logic [`ADD_WIDTH-1:0] csum_model;

	tb_clock i_clock (
		.clk (clk)
	);

	add_share_top i_dut (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.acc_clear    (acc_clear),
		.acc          (acc),
		.acc_busy     (acc_busy),
		.word_valid   (word_valid),
		.word         (word),
		.csum_clear   (csum_clear),
		.csum         (csum),
		.csum_busy    (csum_busy)
	);

	task automatic check_acc(input logic [`ADD_WIDTH-1:0] expected,
		input logic [`ADD_WIDTH-1:0] observed);
		if (observed !== expected) begin
			$display("FAILED at %0t ns: acc expected %h, observed %h", $time, expected, observed);
			error_count++;
		end
	endtask

	task automatic check_csum(input logic [`ADD_WIDTH-1:0] expected,
		input logic [`ADD_WIDTH-1:0] observed);
		if (observed !== expected) begin
			$display("FAILED at %0t ns: csum expected %h, observed %h", $time, expected, observed);
			error_count++;
		end
	endtask

	task automatic check_busy(input logic expected, input logic observed, input string name);
		if (observed !== expected) begin
			$display("FAILED at %0t ns: %s expected %b, observed %b", $time, name, expected,
				observed);
			error_count++;
		end
	endtask

	function automatic string op_name(input int op);
		case (op)
			0: return "accumulate";
			1: return "checksum";
			2: return "both";
			3: return "clear acc";
			default: return "clear csum";
		endcase
	endfunction

	// One-cycle strobe, 0 sample, 1 word, 2 both, 3 and 4 clears
	task automatic drive_op(input int op, input logic [`ADD_WIDTH-1:0] v1,
		input logic [`ADD_WIDTH-1:0] v2);
		@(posedge clk);
		case (op)
			0: begin
				sample_valid <= 1'b1;
				sample       <= v1;
			end
			1: begin
				word_valid <= 1'b1;
				word       <= v1;
			end
			2: begin
				sample_valid <= 1'b1;
				sample       <= v1;
				word_valid   <= 1'b1;
				word         <= v2;
			end
			3: acc_clear <= 1'b1;
			default: csum_clear <= 1'b1;
		endcase
		@(posedge clk);
		sample_valid <= 1'b0;
		word_valid   <= 1'b0;
		acc_clear    <= 1'b0;
		csum_clear   <= 1'b0;
	endtask

	// Outputs are looked at on the falling edge
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while ((acc_busy || csum_busy) && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (acc_busy || csum_busy) begin
			$display("Timeout in test %0d: busy still high after %0d cycles",
				test_no, TIMEOUT_CYCLES);
			timed_out = 1'b1;
		end
	endtask

	task automatic update_model(input int op, input logic [`ADD_WIDTH-1:0] v1,
		input logic [`ADD_WIDTH-1:0] v2);
		logic [`ADD_WIDTH:0]   total;
		logic [`ADD_WIDTH-1:0] w;
		w = (op == 2) ? v2 : v1;
		// Truncation to the operand width gives the wrap
		if (op == 0 || op == 2)
			acc_model = acc_model + v1;
		if (op == 1 || op == 2) begin
			total      = {1'b0, csum_model} + {1'b0, w};
			csum_model = total[`ADD_WIDTH-1:0] + {{(`ADD_WIDTH-1){1'b0}}, total[`ADD_WIDTH]};
		end
		if (op == 3)
			acc_model = '0;
		if (op == 4)
			csum_model = '0;
	endtask

	// Biased toward all ones and alternating bits to stress the carry tree
	task automatic next_value(output logic [`ADD_WIDTH-1:0] v);
		int r;
		r = $random(seed);
		case (r[2:0])
			3'd0: v = '1;
			3'd1: v = {(`ADD_WIDTH/2){2'b10}};
			3'd2: v = {(`ADD_WIDTH/2){2'b01}};
			default: v = r[`ADD_WIDTH+2:3];
		endcase
	endtask

	task automatic run_test(input int op, input logic [`ADD_WIDTH-1:0] v1,
		input logic [`ADD_WIDTH-1:0] v2, input logic [`ADD_WIDTH-1:0] exp_acc,
		input logic [`ADD_WIDTH-1:0] exp_csum);
		int errors_before;
		errors_before = error_count;
		test_no++;
		drive_op(op, v1, v2);
		// A strobe raises busy of its own client only
		@(negedge clk);
		check_busy(op == 0 || op == 2, acc_busy, "acc_busy");
		check_busy(op == 1 || op == 2, csum_busy, "csum_busy");
		wait_idle();
		check_acc(exp_acc, acc);
		check_csum(exp_csum, csum);
		if (error_count == errors_before && !timed_out) begin
			pass_count++;
			$display("test %0d %s: ok", test_no, op_name(op));
		end else begin
			fail_count++;
			$display("test %0d %s: mismatch", test_no, op_name(op));
		end
	endtask

	initial begin
		int                    fd;
		int                    n;
		int                    op;
		string                 line;
		logic [`ADD_WIDTH-1:0] v1;
		logic [`ADD_WIDTH-1:0] v2;
		logic [`ADD_WIDTH-1:0] exp_acc;
		logic [`ADD_WIDTH-1:0] exp_csum;

		seed         = 32'hfa04;
		test_no      = 0;
		pass_count   = 0;
		fail_count   = 0;
		error_count  = 0;
		timed_out    = 1'b0;
		file_error   = 1'b0;
		acc_model    = '0;
		csum_model   = '0;
		reset        <= 1'b1;
		sample_valid <= 1'b0;
		sample       <= '0;
		acc_clear    <= 1'b0;
		word_valid   <= 1'b0;
		word         <= '0;
		csum_clear   <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		fd = $fopen("dv/add_share_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/add_share_cases.txt");
			file_error = 1'b1;
		end else begin
			while (!timed_out && $fgets(line, fd) > 0) begin
				// Comment and blank lines do not parse to five fields
				n = $sscanf(line, "%d %h %h %h %h", op, v1, v2, exp_acc, exp_csum);
				if (n == 5) begin
					run_test(op, v1, v2, exp_acc, exp_csum);
					acc_model  = exp_acc;
					csum_model = exp_csum;
				end
			end
			$fclose(fd);
		end

		for (int k = 0; k < RANDOM_OPS && !timed_out && !file_error; k++) begin
			op = $unsigned($random(seed)) % 5;
			next_value(v1);
			next_value(v2);
			update_model(op, v1, v2);
			run_test(op, v1, v2, acc_model, csum_model);
		end

		$display("tests %0d, passed %0d, failed %0d", test_no, pass_count, fail_count);
		if (fail_count == 0 && !timed_out && !file_error && test_no > 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* dv/add_share_cases.txt */
# op: 0 accumulate, 1 checksum, 2 both (value2 is the word), 3 clear acc, 4 clear csum
# columns: op value1 value2 expected_acc expected_csum, values in hex
0 3fff 0000 3fff 0000
0 0001 0000 0000 0000
1 3fff 0000 0000 3fff
1 0002 0000 0000 0002
2 1234 2abc 1234 2abe
3 0000 0000 0000 2abe
0 0555 0000 0555 2abe
4 0000 0000 0555 0000
2 3aab 2aaa 0000 2aaa
2 2aaa 1555 2aaa 3fff
1 0001 0000 2aaa 0001
1 3ffe 0000 2aaa 3fff
1 3fff 0000 2aaa 3fff
0 1555 0000 3fff 3fff
0 3fff 0000 3ffe 3fff
2 0002 0001 0000 0001
3 0000 0000 0000 0001
4 0000 0000 0000 0000

/* sources.f */
+incdir+rtl
rtl/adder_pkg.sv
rtl/ling_adder.sv
rtl/adder_arbiter.sv
rtl/accum_client.sv
rtl/csum_client.sv
rtl/add_share_top.sv
dv/tb_clock.sv
dv/tb_add_share.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_add_share
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
